// ==== common/dodge_pkg.sv ====
/*
 * Shared definitions for the LED-matrix dodge game
 * - Matrix, frame, score and button types
 * - Obstacle level patterns and player start position
 * - MAX7219 word layout and init sequence
 * - Game state encoding
 */
package dodge_pkg;

	localparam int NUM_ROWS = 8;

	// Bit 7 is the leftmost column
	typedef logic [7:0] row_t;

	// Index 0 is the bottom row
	typedef row_t [NUM_ROWS-1:0] frame_t;

	typedef logic [7:0] score_t;

	// Debounced press pulses
	typedef struct packed {
		logic start;
		logic left;
		logic right;
	} buttons_t;

	//############################################################
	// Obstacle levels, entry 0 enters the top row first
	//############################################################
	localparam int NUM_LEVELS = 4;

	typedef row_t [0:NUM_ROWS-1] pattern_t;

	localparam pattern_t [0:NUM_LEVELS-1] LEVEL_PATTERNS = '{
		'{8'b11101101, 8'b00001100, 8'b00000000, 8'b11000000,
		  8'b00000000, 8'b00011000, 8'b00000000, 8'b00000000},
		'{8'b10101111, 8'b11000000, 8'b00000000, 8'b00011100,
		  8'b00000000, 8'b00001110, 8'b00000000, 8'b00000000},
		'{8'b11101101, 8'b11000110, 8'b00000000, 8'b11110000,
		  8'b00000000, 8'b11000110, 8'b00000000, 8'b00000000},
		'{8'b11101101, 8'b01010101, 8'b00000000, 8'b11011011,
		  8'b00000000, 8'b11111110, 8'b00000000, 8'b00000000}
	};

	// Single dot in column 4
	localparam row_t PLAYER_START = 8'b00010000;

	//############################################################
	// MAX7219 serial word
	//############################################################
	typedef struct packed {
		logic [3:0] pad;
		logic [3:0] addr;
		row_t       data;
	} max_word_t;

	// Digit 0 register, rows follow at consecutive addresses
	localparam logic [3:0] ADDR_DIGIT0 = 4'h1;

	localparam int NUM_INIT_WORDS = 5;

	// Shutdown off, scan all rows, intensity, no decode, test off
	localparam max_word_t [0:NUM_INIT_WORDS-1] MAX_INIT_WORDS = '{
		max_word_t'(16'h0C01),
		max_word_t'(16'h0B07),
		max_word_t'(16'h0A0A),
		max_word_t'(16'h0900),
		max_word_t'(16'h0F00)
	};

	typedef enum logic [1:0] {
		GS_IDLE,
		GS_RUN,
		GS_OVER
	} game_state_e;

endpackage

// ==== src/button_debounce.sv ====
/*
 * Button debouncer
 * Synchronizes an active-low button, waits for a stable level
 * and emits a one-cycle pulse on each accepted press
 */
`timescale 1ns/1ps

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = 500_000
) (
	input  logic clock_50,
	input  logic arst_n,
	input  logic button,
	output logic press
);
	localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	typedef logic [CNT_W-1:0] cnt_t;

	logic sync0_q;
	logic sync1_q;
	logic level_q;
	cnt_t cnt_q;
	logic stable;

	assign stable = (cnt_q == cnt_t'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync0_q <= 1'b0;
			sync1_q <= 1'b0;
			level_q <= 1'b0;
			cnt_q   <= '0;
			press   <= 1'b0;
		end else begin
			// Pressed reads as high after the inversion
			sync0_q <= ~button;
			sync1_q <= sync0_q;
			press   <= 1'b0;
			if (sync1_q == level_q) begin
				cnt_q <= '0;
			end else if (stable) begin
				cnt_q   <= '0;
				level_q <= sync1_q;
				press   <= sync1_q;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	a_press_single : assert property (@(posedge clock_50) disable iff (!arst_n)
		press |=> !press);

endmodule

// ==== src/player_row.sv ====
/*
 * Player position in the bottom row
 * One-hot dot moved left or right by press pulses,
 * saturating at both edges and held while frozen
 */
`timescale 1ns/1ps

module player_row (
	input  logic             clock_50,
	input  logic             arst_n,
	input  logic             move_left,
	input  logic             move_right,
	input  logic             frozen,
	output dodge_pkg::row_t  player
);
	import dodge_pkg::*;

	logic at_left;
	logic at_right;

	// Column 7 is the left edge
	assign at_left  = player[7];
	assign at_right = player[0];

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			player <= PLAYER_START;
		end else if (!frozen) begin
			if (move_left && !at_left) begin
				player <= {player[6:0], 1'b0};
			end else if (move_right && !at_right) begin
				player <= {1'b0, player[7:1]};
			end
		end
	end

	a_player_onehot : assert property (@(posedge clock_50) disable iff (!arst_n)
		$onehot(player));

endmodule

// ==== playfield/obstacle_field.sv ====
/*
 * Obstacle field
 * - Eight row registers shifted down on each scroll tick
 * - New top rows taken from the current level pattern
 * - Entry and level counters, levels used in turn
 */
`timescale 1ns/1ps

module obstacle_field (
	input  logic              clock_50,
	input  logic              arst_n,
	input  logic              scroll_tick,
	input  logic              clear_field,
	output dodge_pkg::frame_t field
);
	import dodge_pkg::*;

	localparam int ENTRY_W = $clog2(NUM_ROWS);
	localparam int LEVEL_W = $clog2(NUM_LEVELS);

	typedef logic [ENTRY_W-1:0] entry_t;
	typedef logic [LEVEL_W-1:0] level_t;

	entry_t entry_q;
	level_t level_q;
	row_t   new_row;
	logic   last_entry;

	assign new_row    = LEVEL_PATTERNS[level_q][entry_q];
	assign last_entry = (entry_q == entry_t'(NUM_ROWS - 1));

	//############################################################
	// Row shift registers
	//############################################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			field <= '0;
		end else if (clear_field) begin
			field <= '0;
		end else if (scroll_tick) begin
			// Bottom row drops out, pattern row enters at the top
			field <= {new_row, field[NUM_ROWS-1:1]};
		end
	end

	//############################################################
	// Pattern position
	//############################################################
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			entry_q <= '0;
			level_q <= '0;
		end else if (clear_field) begin
			entry_q <= '0;
			level_q <= '0;
		end else if (scroll_tick) begin
			if (last_entry) begin
				entry_q <= '0;
				if (level_q == level_t'(NUM_LEVELS - 1)) begin
					level_q <= '0;
				end else begin
					level_q <= level_q + 1'b1;
				end
			end else begin
				entry_q <= entry_q + 1'b1;
			end
		end
	end

endmodule

// ==== playfield/game_ctrl.sv ====
/*
 * Game control
 * - Idle / run / over state machine
 * - Scroll prescaler and score counter
 * - Collision check of the bottom row against the player
 */
`timescale 1ns/1ps

module game_ctrl #(
	parameter int SCROLL_CYCLES = 12_500_000
) (
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  logic                   start,
	input  dodge_pkg::row_t        player,
	input  dodge_pkg::row_t        bottom_row,
	output logic                   scroll_tick,
	output logic                   clear_field,
	output dodge_pkg::game_state_e state,
	output dodge_pkg::score_t      score
);
	import dodge_pkg::*;

	localparam int PRESC_W = (SCROLL_CYCLES > 1) ? $clog2(SCROLL_CYCLES) : 1;

	typedef logic [PRESC_W-1:0] presc_t;

	presc_t presc_q;
	logic   check_q;
	logic   hit;

	// Prescaler rests at zero outside the run state
	assign scroll_tick = (presc_q == presc_t'(SCROLL_CYCLES - 1));

	// Field has shifted by the time check_q is set
	assign hit = |(bottom_row & player);

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state       <= GS_IDLE;
			presc_q     <= '0;
			score       <= '0;
			clear_field <= 1'b0;
			check_q     <= 1'b0;
		end else begin
			clear_field <= 1'b0;
			check_q     <= scroll_tick;
			case (state)
				GS_IDLE, GS_OVER: begin
					if (start) begin
						state       <= GS_RUN;
						presc_q     <= '0;
						score       <= '0;
						clear_field <= 1'b1;
					end
				end
				GS_RUN: begin
					if (scroll_tick) begin
						presc_q <= '0;
						score   <= score + 1'b1;
					end else begin
						presc_q <= presc_q + 1'b1;
					end
					if (check_q && hit) begin
						state   <= GS_OVER;
						presc_q <= '0;
					end
				end
				default: state <= GS_IDLE;
			endcase
		end
	end

	a_tick_in_run : assert property (@(posedge clock_50) disable iff (!arst_n)
		scroll_tick |-> state == GS_RUN);

endmodule

// ==== max7219/max7219_driver.sv ====
/*
 * MAX7219 serial driver
 * - Five init words sent once after reset
 * - Then continuous sweeps of eight digit words, one per frame row
 * - Frame latched as each sweep starts
 * - Bit clock divided from the system clock
 */
`timescale 1ns/1ps

module max7219_driver #(
	parameter int SCLK_DIV = 4
) (
	input  logic              clock_50,
	input  logic              arst_n,
	input  dodge_pkg::frame_t frame,
	output logic              din,
	output logic              ncs,
	output logic              sclk
);
	import dodge_pkg::*;

	localparam int DIV_W     = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
	localparam int WORD_BITS = $bits(max_word_t);

	typedef logic [DIV_W-1:0]               div_t;
	typedef logic [$clog2(WORD_BITS)-1:0]   bit_idx_t;
	typedef logic [$clog2(NUM_ROWS)-1:0]    word_idx_t;
	typedef enum logic {DRV_GAP, DRV_SHIFT} drv_state_e;

	div_t       div_q;
	logic       half_tick;
	drv_state_e state_q;
	logic       gap_q;
	bit_idx_t   bit_q;
	word_idx_t  idx_q;
	logic       init_done_q;
	logic       load;
	logic       last_bit;
	frame_t     frame_q;
	max_word_t  shift_q;
	max_word_t  next_word;
	row_t       next_row;

	//############################################################
	// Half-period tick of the bit clock
	//############################################################
	assign half_tick = (div_q == div_t'(SCLK_DIV - 1));

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			div_q <= '0;
		end else if (half_tick) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	//############################################################
	// Word sequencer
	//############################################################
	// Row 0 comes straight from the input while it is being latched
	always_comb begin
		next_row = (idx_q == '0) ? frame[0] : frame_q[idx_q];
		if (init_done_q) begin
			next_word.pad  = '0;
			next_word.addr = ADDR_DIGIT0 + 4'(idx_q);
			next_word.data = next_row;
		end else begin
			next_word = MAX_INIT_WORDS[idx_q];
		end
	end

	assign load     = half_tick && (state_q == DRV_GAP) && gap_q;
	assign last_bit = (bit_q == bit_idx_t'(WORD_BITS - 1));

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state_q     <= DRV_GAP;
			gap_q       <= 1'b0;
			bit_q       <= '0;
			idx_q       <= '0;
			init_done_q <= 1'b0;
			ncs         <= 1'b1;
			sclk        <= 1'b0;
		end else if (half_tick) begin
			case (state_q)
				DRV_GAP: begin
					gap_q <= ~gap_q;
					if (gap_q) begin
						ncs     <= 1'b0;
						bit_q   <= '0;
						state_q <= DRV_SHIFT;
						if (!init_done_q && idx_q == word_idx_t'(NUM_INIT_WORDS - 1)) begin
							init_done_q <= 1'b1;
							idx_q       <= '0;
						end else begin
							idx_q <= idx_q + 1'b1;
						end
					end
				end
				DRV_SHIFT: begin
					sclk <= ~sclk;
					// Falling edge ends the bit
					if (sclk) begin
						bit_q <= bit_q + 1'b1;
						if (last_bit) begin
							ncs     <= 1'b1;
							state_q <= DRV_GAP;
						end
					end
				end
				default: state_q <= DRV_GAP;
			endcase
		end
	end

	// Word and frame payload
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			shift_q <= '0;
			frame_q <= '0;
		end else if (load) begin
			shift_q <= next_word;
			if (init_done_q && idx_q == '0) begin
				frame_q <= frame;
			end
		end else if (half_tick && state_q == DRV_SHIFT && sclk && !last_bit) begin
			shift_q <= max_word_t'({shift_q[WORD_BITS-2:0], 1'b0});
		end
	end

	assign din = !ncs && shift_q[WORD_BITS-1];

	a_sclk_idle_low : assert property (@(posedge clock_50) disable iff (!arst_n)
		ncs |-> !sclk);

endmodule

// ==== src/dodge_top.sv ====
/*
 * Dodge game top level
 * Button debouncers, player, obstacle field, game control,
 * frame composition and MAX7219 driver
 */
`timescale 1ns/1ps

module dodge_top #(
	parameter int DEBOUNCE_CYCLES = 500_000,
	parameter int SCROLL_CYCLES   = 12_500_000,
	parameter int SCLK_DIV        = 4
) (
	input  logic              clock_50,
	input  logic              arst_n,
	input  logic              start_button,
	input  logic              left_button,
	input  logic              right_button,
	output logic              max7219_din,
	output logic              max7219_ncs,
	output logic              max7219_clk,
	output dodge_pkg::score_t score,
	output logic              game_over
);
	import dodge_pkg::*;

	buttons_t    press;
	row_t        player;
	frame_t      field;
	frame_t      player_frame;
	frame_t      frame;
	logic        scroll_tick;
	logic        clear_field;
	game_state_e state;

	//############################################################
	// Inputs
	//############################################################
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) start_db_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button   (start_button),
		.press    (press.start)
	);

	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) left_db_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button   (left_button),
		.press    (press.left)
	);

	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) right_db_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button   (right_button),
		.press    (press.right)
	);

	//############################################################
	// Game
	//############################################################
	player_row player_row_i (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.move_left  (press.left),
		.move_right (press.right),
		.frozen     (game_over),
		.player     (player)
	);

	obstacle_field obstacle_field_i (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.scroll_tick (scroll_tick),
		.clear_field (clear_field),
		.field       (field)
	);

	game_ctrl #(.SCROLL_CYCLES(SCROLL_CYCLES)) game_ctrl_i (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start       (press.start),
		.player      (player),
		.bottom_row  (field[0]),
		.scroll_tick (scroll_tick),
		.clear_field (clear_field),
		.state       (state),
		.score       (score)
	);

	assign game_over = (state == GS_OVER);

	//############################################################
	// Display
	//############################################################
	// Player only ever occupies the bottom row
	always_comb begin
		player_frame    = '0;
		player_frame[0] = player;
	end

	assign frame = field | player_frame;

	max7219_driver #(.SCLK_DIV(SCLK_DIV)) max7219_driver_i (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.frame    (frame),
		.din      (max7219_din),
		.ncs      (max7219_ncs),
		.sclk     (max7219_clk)
	);

endmodule

// ==== dv/tb_dodge_checks.svh ====
/*
 * Testbench helpers
 * - Fibonacci LFSR for button bounce
 * - Reference functions for player moves, field scroll and frames
 * - Typed compare tasks that count errors
 */
`ifndef TB_DODGE_CHECKS_SVH
`define TB_DODGE_CHECKS_SVH

// Taps 17 and 14, new bit enters at the bottom
function automatic logic [16:0] lfsr_next(input logic [16:0] s);
	return {s[15:0], s[16] ^ s[13]};
endfunction

//############################################################
// Reference model
//############################################################
// Bit 7 is the left edge, moves stop at both edges
function automatic row_t moved_player(input row_t p, input logic left, input logic right);
	if (left && !p[7]) begin
		return p << 1;
	end else if (right && !p[0]) begin
		return p >> 1;
	end
	return p;
endfunction

// Everything moves one row down, new row enters at the top
function automatic frame_t scrolled_field(input frame_t f, input row_t new_row);
	return {new_row, f[NUM_ROWS-1:1]};
endfunction

function automatic int next_entry(input int entry);
	return (entry + 1) % NUM_ROWS;
endfunction

function automatic int next_level(input int level, input int entry);
	if (entry == NUM_ROWS - 1) begin
		return (level + 1) % NUM_LEVELS;
	end
	return level;
endfunction

function automatic logic overlaps(input row_t a, input row_t b);
	return |(a & b);
endfunction

function automatic frame_t expected_frame(input frame_t f, input row_t p);
	frame_t r;
	r    = f;
	r[0] = f[0] | p;
	return r;
endfunction

// Lowest column that no row of the level ever uses
function automatic row_t first_clear_column(input int level);
	row_t used;
	int   r;
	int   c;
	used = '0;
	for (r = 0; r < NUM_ROWS; r++) begin
		used = used | LEVEL_PATTERNS[level][r];
	end
	for (c = 0; c < 8; c++) begin
		if (!used[c]) begin
			return row_t'(1) << c;
		end
	end
	return '0;
endfunction

// Score at which the bottom row first hits a still player, 0 if never
function automatic int predict_over_score(input row_t p);
	frame_t f;
	int     level;
	int     entry;
	int     t;
	f     = '0;
	level = 0;
	entry = 0;
	for (t = 1; t <= MAX_TICKS; t++) begin
		f     = scrolled_field(f, LEVEL_PATTERNS[level][entry]);
		level = next_level(level, entry);
		entry = next_entry(entry);
		if (overlaps(f[0], p)) begin
			return t;
		end
	end
	return 0;
endfunction

//############################################################
// Compare tasks
//############################################################
task automatic check_word(input max_word_t got, input max_word_t exp, input string what);
	if (got !== exp) begin
		word_errors = word_errors + 1;
		$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_frame(input frame_t got, input frame_t exp, input string what);
	if (got !== exp) begin
		frame_errors = frame_errors + 1;
		$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_score(input score_t got, input score_t exp, input string what);
	if (got !== exp) begin
		score_errors = score_errors + 1;
		$display("** Error at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		flag_errors = flag_errors + 1;
		$display("** Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_count(input int got, input int exp, input string what);
	if (got != exp) begin
		count_errors = count_errors + 1;
		$display("** Error at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
	end
endtask

`endif

// ==== dv/tb_dodge_top.sv ====
/*
 * Testbench for the dodge game top level
 * - Clock, reset and bouncing button stimulus
 * - MAX7219 serial decoder for init words and sweeps
 * - Reference model of player, field and score
 * - Timeout and final error report
 */
`timescale 1ns/1ps

module tb_dodge_top;
	import dodge_pkg::*;

	localparam int DEBOUNCE_CYCLES = 4;
	localparam int SCROLL_CYCLES   = 300;
	localparam int SCLK_DIV        = 2;

	localparam int BTN_START = 0;
	localparam int BTN_LEFT  = 1;
	localparam int BTN_RIGHT = 2;

	localparam int WORD_BITS        = $bits(max_word_t);
	localparam int MAX_TICKS        = (NUM_LEVELS + 1) * NUM_ROWS;
	localparam int STEADY_CYCLES    = 4 * DEBOUNCE_CYCLES;
	localparam int PRESS_MAX_CYCLES = 8 * (DEBOUNCE_CYCLES - 1) + 2 * STEADY_CYCLES + 1;
	// Each word is 16 bit periods plus one period with ncs high
	localparam int SWEEP_CYCLES     = NUM_ROWS * (WORD_BITS + 1) * 2 * SCLK_DIV;
	localparam int LONGEST_RUN      = 3 * NUM_ROWS * SCROLL_CYCLES;
	localparam int NUM_PRESSES      = 24;
	localparam int NUM_SWEEP_WAITS  = 12;
	localparam int NUM_RUNS         = 2;
	localparam int TIMEOUT_CYCLES   = NUM_PRESSES * PRESS_MAX_CYCLES
		+ NUM_SWEEP_WAITS * 3 * SWEEP_CYCLES
		+ NUM_RUNS * (LONGEST_RUN + 3 * SCROLL_CYCLES) + 2000;

	logic   clock_50 = 1'b0;
	logic   arst_n;
	logic   start_button;
	logic   left_button;
	logic   right_button;
	logic   max7219_din;
	logic   max7219_ncs;
	logic   max7219_clk;
	score_t score;
	logic   game_over;

	int word_errors  = 0;
	int frame_errors = 0;
	int score_errors = 0;
	int flag_errors  = 0;
	int count_errors = 0;
	int other_errors = 0;
	int total_errors;

	// Serial decoder
	logic [WORD_BITS-1:0] rx_shift    = '0;
	int                   rx_bits     = 0;
	max_word_t            rx_word;
	int                   init_count  = 0;
	int                   row_idx     = 0;
	frame_t               rx_frame    = '0;
	frame_t               sweep_frame = '0;
	int                   sweep_count = 0;

	// Score monitor
	int     cycle_count        = 0;
	score_t seen_score         = '0;
	int     score_changes      = 0;
	int     score_change_cycle = 0;

	// Model state
	row_t   model_player;
	frame_t model_field;
	int     model_level;
	int     model_entry;
	score_t model_score;
	logic   model_over;

	logic [16:0] lfsr_q = 17'd71746;

	int   i;
	int   over_score;
	row_t target;

	`include "tb_dodge_checks.svh"

	dodge_top #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.SCROLL_CYCLES   (SCROLL_CYCLES),
		.SCLK_DIV        (SCLK_DIV)
	) dodge_top_i (
		.clock_50     (clock_50),
		.arst_n       (arst_n),
		.start_button (start_button),
		.left_button  (left_button),
		.right_button (right_button),
		.max7219_din  (max7219_din),
		.max7219_ncs  (max7219_ncs),
		.max7219_clk  (max7219_clk),
		.score        (score),
		.game_over    (game_over)
	);

	always #5 clock_50 = ~clock_50;

	//############################################################
	// MAX7219 decoder
	//############################################################
	always @(posedge max7219_clk) begin
		rx_shift = {rx_shift[WORD_BITS-2:0], max7219_din};
		rx_bits  = rx_bits + 1;
	end

	always @(posedge max7219_ncs) begin
		if (arst_n && rx_bits == WORD_BITS) begin
			rx_word = max_word_t'(rx_shift);
			if (init_count < NUM_INIT_WORDS) begin
				check_word(rx_word, MAX_INIT_WORDS[init_count], "init word");
				init_count = init_count + 1;
			end else begin
				// Digit address k+1 carries row k
				check_flag(rx_word.pad == 4'h0 && rx_word.addr == 4'(row_idx + 1), 1'b1,
					"sweep word address");
				rx_frame[row_idx] = rx_word.data;
				if (row_idx == NUM_ROWS - 1) begin
					sweep_frame = rx_frame;
					sweep_count = sweep_count + 1;
					row_idx     = 0;
				end else begin
					row_idx = row_idx + 1;
				end
			end
		end else if (arst_n && rx_bits != 0) begin
			other_errors = other_errors + 1;
			$display("Serial word ended after %0d bits instead of %0d", rx_bits, WORD_BITS);
		end
		rx_bits = 0;
	end

	//############################################################
	// Score monitor and timeout
	//############################################################
	always @(negedge clock_50) begin
		if (arst_n && score !== seen_score) begin
			seen_score         = score;
			score_change_cycle = cycle_count;
			score_changes      = score_changes + 1;
		end
	end

	always @(posedge clock_50) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	//############################################################
	// Stimulus tasks
	//############################################################
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock_50);
		#1;
	endtask

	task automatic take_bits(input int n, output int v);
		int k;
		v = 0;
		for (k = 0; k < n; k++) begin
			v      = (v << 1) | int'(lfsr_q[16]);
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic drive_button(input int which, input logic level);
		case (which)
			BTN_START: start_button = level;
			BTN_LEFT:  left_button  = level;
			default:   right_button = level;
		endcase
	endtask

	// Bounce shorter than the debounce time, then an optional steady press
	task automatic press_button(input int which, input logic steady);
		int glitches;
		int len;
		int g;
		@(posedge clock_50);
		#1;
		take_bits(2, glitches);
		for (g = 0; g <= glitches; g++) begin
			take_bits(2, len);
			drive_button(which, 1'b0);
			wait_cycles(1 + len % (DEBOUNCE_CYCLES - 1));
			take_bits(2, len);
			drive_button(which, 1'b1);
			wait_cycles(1 + len % (DEBOUNCE_CYCLES - 1));
		end
		if (steady) begin
			drive_button(which, 1'b0);
			wait_cycles(STEADY_CYCLES);
			drive_button(which, 1'b1);
		end
		wait_cycles(STEADY_CYCLES);
	endtask

	task automatic move_press(input int which);
		press_button(which, 1'b1);
		if (!model_over) begin
			model_player = moved_player(model_player, which == BTN_LEFT, which == BTN_RIGHT);
		end
	endtask

	// Compare a sweep that was latched after this call
	task automatic check_display(input string what);
		int target_count;
		target_count = sweep_count + 2;
		wait (sweep_count >= target_count);
		check_frame(sweep_frame, expected_frame(model_field, model_player), what);
	endtask

	task automatic start_game();
		press_button(BTN_START, 1'b1);
		model_field = '0;
		model_level = 0;
		model_entry = 0;
		model_score = '0;
		model_over  = 1'b0;
		check_score(score, model_score, "score after start");
		check_flag(game_over, 1'b0, "game_over after start");
	endtask

	task automatic step_model();
		model_field = scrolled_field(model_field, LEVEL_PATTERNS[model_level][model_entry]);
		model_level = next_level(model_level, model_entry);
		model_entry = next_entry(model_entry);
		model_score = model_score + 1'b1;
		model_over  = overlaps(model_field[0], model_player);
	endtask

	// Follow each tick until the model or the DUT ends the game
	task automatic run_game();
		int base;
		int ticks;
		int prev_cycle;
		ticks      = 0;
		prev_cycle = 0;
		while (!model_over && !game_over && ticks < MAX_TICKS) begin
			base = score_changes;
			wait (score_changes > base);
			ticks = ticks + 1;
			if (ticks > 1) begin
				check_count(score_change_cycle - prev_cycle, SCROLL_CYCLES,
					"cycles between score steps");
			end
			prev_cycle = score_change_cycle;
			step_model();
			check_score(score, model_score, "score after tick");
			// Collision shows one cycle after the tick
			@(negedge clock_50);
			@(negedge clock_50);
			check_flag(game_over, model_over, "game_over after tick");
		end
		if (!model_over) begin
			other_errors = other_errors + 1;
			$display("Run stopped at score %0d without the predicted collision", score);
		end
		repeat (2 * SCROLL_CYCLES) @(negedge clock_50);
		check_score(score, model_score, "score held in game over");
		check_flag(game_over, 1'b1, "game_over held");
	endtask

	//############################################################
	// Test sequence
	//############################################################
	initial begin
		arst_n       = 1'b0;
		start_button = 1'b1;
		left_button  = 1'b1;
		right_button = 1'b1;
		model_player = PLAYER_START;
		model_field  = '0;
		model_level  = 0;
		model_entry  = 0;
		model_score  = '0;
		model_over   = 1'b0;
		repeat (16) @(posedge clock_50);
		#1;
		arst_n = 1'b1;

		// Init words, then idle sweeps
		wait (sweep_count >= 1);
		check_frame(sweep_frame, expected_frame(model_field, model_player), "first idle sweep");
		check_display("idle sweep");

		// Moves to both edges and past them
		for (i = 0; i < 4; i++) begin
			move_press(BTN_LEFT);
		end
		check_display("after left presses");
		for (i = 0; i < 8; i++) begin
			move_press(BTN_RIGHT);
		end
		check_display("after right presses");
		press_button(BTN_LEFT, 1'b0);
		press_button(BTN_RIGHT, 1'b0);
		check_display("after glitches only");

		// Park the player where level 0 never reaches
		target = first_clear_column(0);
		if (target == '0) begin
			other_errors = other_errors + 1;
			$display("Level 0 leaves no column free for the player");
		end else begin
			while (model_player != target) begin
				move_press((target > model_player) ? BTN_LEFT : BTN_RIGHT);
			end
		end
		check_display("player parked");

		over_score = predict_over_score(model_player);
		if (over_score == 0) begin
			other_errors = other_errors + 1;
			$display("Model finds no collision for the parked player");
		end

		start_game();
		run_game();
		check_score(score, score_t'(over_score), "score at game over");

		// Frozen display and restart
		check_display("frozen frame");
		move_press(BTN_LEFT);
		check_display("frozen frame after move press");
		check_score(score, model_score, "score after move in game over");
		start_game();
		run_game();
		check_score(score, score_t'(over_score), "score at second game over");
		check_display("second frozen frame");

		total_errors = word_errors + frame_errors + score_errors + flag_errors
			+ count_errors + other_errors;
		$display("Errors: words %0d, frames %0d, scores %0d, flags %0d, timing %0d, other %0d",
			word_errors, frame_errors, score_errors, flag_errors, count_errors, other_errors);
		if (total_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+dv
common/dodge_pkg.sv
src/button_debounce.sv
src/player_row.sv
playfield/obstacle_field.sv
playfield/game_ctrl.sv
max7219/max7219_driver.sv
src/dodge_top.sv
dv/tb_dodge_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the dodge game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_dodge_top

out=$(./obj_dir/Vtb_dodge_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
